// ==== source/frame_loop_cfg.svh ====
// sizes and byte offsets for untagged Ethernet II frames carrying IPv4; no VLAN or IPv6.
`ifndef FRAME_LOOP_CFG_SVH
`define FRAME_LOOP_CFG_SVH

// buffer sizes.
`define FRAME_FIFO_DEPTH 256
`define RESULT_FIFO_DEPTH 16

// ethernet header.
`define ETH_HDR_LEN 14
`define ETH_TYPE_OFS 12
`define ETH_TYPE_IPV4 16'h0800

// offsets inside the IPv4 header.
`define IP_TLEN_OFS 2
`define IP_PROTO_OFS 9
`define IP_SRC_OFS 12
`define IP_HDR_MIN 20

// checksum field inside the L4 header.
`define UDP_CSUM_OFS 6
`define TCP_CSUM_OFS 16

`endif

// ==== source/frame_loop_pkg.sv ====
// user bit 0 marks an error and bit 1 requests the checksum fix; field order sets the layout.
package frame_loop_pkg;

	// input byte with its two-bit user field.
	typedef struct packed {
		logic [7:0] data;
		logic [1:0] user;
		logic last;
	} in_beat_t;

	// output byte, user carries the error mark only.
	typedef struct packed {
		logic [7:0] data;
		logic user;
		logic last;
	} out_beat_t;

	// per-frame entry held until the frame leaves.
	typedef struct packed {
		logic [15:0] csum;
		logic [15:0] pos;
		logic fix;
	} csum_result_t;

	// checksum unit report at frame end.
	typedef struct packed {
		logic [15:0] csum;
		logic [15:0] pos;
		logic found;
	} csum_calc_t;

endpackage

// ==== source/transport_checksum.sv ====
// IPv4 TCP/UDP only; options covered by header length; found needs the whole L4 segment present.
`timescale 1ns/10ps
`include "frame_loop_cfg.svh"

module transport_checksum (
	input logic m_axis_clk,
	input logic rst_n_m,

	input logic [7:0] data,
	input logic valid,
	input logic last,

	output logic done,
	output frame_loop_pkg::csum_calc_t calc
);
	localparam logic [15:0] ofs_ip = 16'(`ETH_HDR_LEN);
	localparam logic [15:0] ofs_type = 16'(`ETH_TYPE_OFS);
	localparam logic [15:0] ofs_tlen = 16'(`ETH_HDR_LEN + `IP_TLEN_OFS);
	localparam logic [15:0] ofs_proto = 16'(`ETH_HDR_LEN + `IP_PROTO_OFS);
	localparam logic [15:0] ofs_addr = 16'(`ETH_HDR_LEN + `IP_SRC_OFS);
	localparam logic [15:0] ofs_l4_min = 16'(`ETH_HDR_LEN + `IP_HDR_MIN);
	localparam logic [7:0] proto_tcp = 8'd6;
	localparam logic [7:0] proto_udp = 8'd17;

	logic [15:0] cnt;
	logic [15:0] eth_type;
	logic [3:0] ip_ver;
	logic [3:0] ihl;
	logic [15:0] total_len;
	logic [7:0] proto;
	logic [15:0] acc;

	logic [15:0] l4_start;
	logic [15:0] l4_end;
	logic [15:0] l4_len;
	logic [15:0] field_pos;
	logic in_addr;
	logic in_l4;
	logic in_field;
	logic hdr_ok;
	logic [15:0] term;
	logic [15:0] acc_next;
	logic [15:0] sum_final;

	// 16-bit add with end-around carry.
	function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'd0, s[16]};
	endfunction

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// ranges and running sum
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		l4_start = ofs_ip + {10'd0, ihl, 2'b00};
		l4_end = ofs_ip + total_len;
		l4_len = total_len - {10'd0, ihl, 2'b00};
		field_pos = l4_start + ((proto == proto_tcp) ? 16'(`TCP_CSUM_OFS) : 16'(`UDP_CSUM_OFS));

		in_addr = (cnt >= ofs_addr) && (cnt < ofs_l4_min);
		// stale header fields from the last frame are harmless below the minimum.
		in_l4 = (cnt >= ofs_l4_min) && (cnt >= l4_start) && (cnt < l4_end);
		in_field = (cnt == field_pos) || (cnt == field_pos + 16'd1);

		// each byte lands in its big-endian lane.
		if(in_addr || (in_l4 && ~in_field)) begin
			term = cnt[0] ? {8'h00, data} : {data, 8'h00};
		end else begin
			term = 16'h0000;
		end

		acc_next = ones_add((cnt == 16'd0) ? 16'h0000 : acc, term);
		sum_final = ones_add(ones_add(acc_next, {8'h00, proto}), l4_len);

		hdr_ok = (eth_type == `ETH_TYPE_IPV4) && (ip_ver == 4'd4) && (ihl >= 4'd5) &&
			((proto == proto_tcp) || (proto == proto_udp));
	end

	always_ff @(posedge m_axis_clk) begin
		if(~rst_n_m) begin
			cnt <= 16'd0;
			done <= 1'b0;
		end else begin
			done <= valid & last;
			if(valid) begin
				cnt <= last ? 16'd0 : cnt + 16'd1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// header capture
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge m_axis_clk) begin
		if(valid) begin
			acc <= acc_next;

			case(cnt)
				ofs_type: eth_type[15:8] <= data;
				ofs_type + 16'd1: eth_type[7:0] <= data;
				ofs_ip: {ip_ver, ihl} <= data;
				ofs_tlen: total_len[15:8] <= data;
				ofs_tlen + 16'd1: total_len[7:0] <= data;
				ofs_proto: proto <= data;
				default: ;
			endcase

			if(last) begin
				calc.csum <= ~sum_final;
				calc.pos <= field_pos;
				// field inside the segment and the segment fully received.
				calc.found <= hdr_ok && (cnt + 16'd1 >= l4_end) &&
					(field_pos + 16'd2 <= l4_end);
			end
		end
	end
endmodule

// ==== source/frame_fifo.sv ====
// depth need not be a power of two; a write is refused while full even if a read frees a slot.
`timescale 1ns/10ps

module frame_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int depth = 16
)
(
	input logic m_axis_clk,
	input logic rst_n_m,

	input logic wr,
	input payload_t wr_data,

	input logic rd,
	output payload_t rd_data,

	output logic full,
	output logic empty
);
	localparam int addr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int last_i = depth - 1;
	localparam logic [addr_w-1:0] last_addr = last_i[addr_w-1:0];
	localparam logic [addr_w:0] full_cnt = depth[addr_w:0];

	payload_t mem [depth];

	logic [addr_w-1:0] wr_ptr;
	logic [addr_w-1:0] rd_ptr;
	logic [addr_w:0] count;
	logic do_wr;
	logic do_rd;

	function automatic logic [addr_w-1:0] next_ptr(input logic [addr_w-1:0] p);
		return (p == last_addr) ? '0 : p + 1'b1;
	endfunction

	always_comb begin
		full = (count == full_cnt);
		empty = (count == '0);
		do_wr = wr & ~full;
		do_rd = rd & ~empty;
	end

	// show-ahead, head entry visible without a read.
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge m_axis_clk) begin
		if(do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge m_axis_clk) begin
		if(~rst_n_m) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if(do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end

			if(do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end

			case({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end
endmodule

// ==== source/ingress_guard.sv ====
// input has no ready; a result FIFO that fills in the very cycle a frame starts goes unnoticed.
`timescale 1ns/10ps

module ingress_guard (
	input logic m_axis_clk,
	input logic rst_n_m,

	input logic mode,
	input frame_loop_pkg::in_beat_t s_axis,
	input logic s_axis_tvalid,

	input logic buf_full,
	input logic res_full,

	output logic buf_wr,
	output frame_loop_pkg::out_beat_t buf_beat,

	output logic csum_valid,
	output logic csum_last,
	input logic csum_done,
	input frame_loop_pkg::csum_calc_t csum_calc,

	output logic res_wr,
	output frame_loop_pkg::csum_result_t res_entry
);
	typedef enum logic [1:0] {st_pass, st_wait, st_drop} state_t;

	state_t state;
	logic sof;
	logic mode_q;
	logic in_open;
	logic pend_fix;

	logic start;
	logic mode_now;
	logic overflow;
	logic open_next;
	logic term_wr;

	always_comb begin
		start = s_axis_tvalid & sof;
		mode_now = start ? mode : mode_q;
		overflow = buf_full | (start & res_full);
		open_next = s_axis_tvalid ? ~s_axis.last : in_open;

		// terminating beat once both buffers have room.
		term_wr = (state == st_wait) & ~buf_full & ~res_full;
		buf_wr = term_wr | ((state == st_pass) & s_axis_tvalid & ~overflow);

		buf_beat.data = s_axis.data;
		buf_beat.user = term_wr | (s_axis.last & s_axis.user[0]);
		buf_beat.last = term_wr | s_axis.last;

		// checksum unit sees exactly what the buffer stores.
		csum_valid = buf_wr;
		csum_last = buf_wr & buf_beat.last;

		res_wr = csum_done;
		res_entry.csum = csum_calc.csum;
		res_entry.pos = csum_calc.pos;
		res_entry.fix = pend_fix & csum_calc.found;
	end

	always_ff @(posedge m_axis_clk) begin
		if(~rst_n_m) begin
			state <= st_pass;
			sof <= 1'b1;
			mode_q <= 1'b0;
			in_open <= 1'b0;
			pend_fix <= 1'b0;
		end else begin
			if(s_axis_tvalid) begin
				sof <= s_axis.last;
			end

			if(start) begin
				mode_q <= mode;
			end

			case(state)
				st_pass: begin
					if(s_axis_tvalid & overflow) begin
						state <= st_wait;
						in_open <= ~s_axis.last;
					end else if(s_axis_tvalid & s_axis.last) begin
						pend_fix <= mode_now & s_axis.user[1];
					end
				end
				st_wait: begin
					in_open <= open_next;
					if(term_wr) begin
						pend_fix <= 1'b0;
						state <= open_next ? st_drop : st_pass;
					end
				end
				st_drop: begin
					if(s_axis_tvalid & s_axis.last) begin
						state <= st_pass;
					end
				end
				default: state <= st_pass;
			endcase
		end
	end
endmodule

// ==== source/egress_patcher.sv ====
// one idle cycle between frames; the result head always belongs to the frame being sent.
`timescale 1ns/10ps

module egress_patcher (
	input logic m_axis_clk,
	input logic rst_n_m,

	input frame_loop_pkg::out_beat_t buf_beat,
	input logic buf_empty,
	output logic buf_rd,

	input frame_loop_pkg::csum_result_t res_entry,
	input logic res_empty,
	output logic res_rd,

	output frame_loop_pkg::out_beat_t m_axis,
	output logic m_axis_tvalid,
	input logic m_axis_tready
);
	logic active;
	logic [15:0] count;

	logic xfer;
	logic patch_on;
	logic hit_hi;
	logic hit_lo;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// output and substitution
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		m_axis_tvalid = active & ~buf_empty;
		xfer = m_axis_tvalid & m_axis_tready;
		buf_rd = xfer;
		res_rd = xfer & buf_beat.last;

		// zero result leaves the field as received.
		patch_on = res_entry.fix & (res_entry.csum != 16'h0000);
		hit_hi = patch_on & (count == res_entry.pos);
		hit_lo = patch_on & (count == res_entry.pos + 16'd1);

		m_axis = buf_beat;
		if(hit_hi) begin
			m_axis.data = res_entry.csum[15:8];
		end else if(hit_lo) begin
			m_axis.data = res_entry.csum[7:0];
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame enable and byte count
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge m_axis_clk) begin
		if(~rst_n_m) begin
			active <= 1'b0;
			count <= 16'd0;
		end else begin
			if(~active & ~res_empty) begin
				active <= 1'b1;
			end

			// count moves on transfers only.
			if(xfer) begin
				if(buf_beat.last) begin
					active <= 1'b0;
					count <= 16'd0;
				end else begin
					count <= count + 16'd1;
				end
			end
		end
	end
endmodule

// ==== source/frame_loop.sv ====
// single clock domain, store-and-forward; a frame leaves only after its checksum result is queued.
`timescale 1ns/10ps
`include "frame_loop_cfg.svh"

module frame_loop (
	input logic m_axis_clk,
	input logic rst_n_m,

	input logic mode,

	input frame_loop_pkg::in_beat_t s_axis,
	input logic s_axis_tvalid,

	output frame_loop_pkg::out_beat_t m_axis,
	output logic m_axis_tvalid,
	input logic m_axis_tready
);
	import frame_loop_pkg::*;

	out_beat_t buf_in;
	out_beat_t buf_out;
	logic buf_wr;
	logic buf_rd;
	logic buf_full;
	logic buf_empty;

	csum_calc_t csum_calc;
	logic csum_valid;
	logic csum_last;
	logic csum_done;

	csum_result_t res_in;
	csum_result_t res_out;
	logic res_wr;
	logic res_rd;
	logic res_full;
	logic res_empty;

	ingress_guard u_guard (
		.m_axis_clk(m_axis_clk),
		.rst_n_m(rst_n_m),
		.mode(mode),
		.s_axis(s_axis),
		.s_axis_tvalid(s_axis_tvalid),
		.buf_full(buf_full),
		.res_full(res_full),
		.buf_wr(buf_wr),
		.buf_beat(buf_in),
		.csum_valid(csum_valid),
		.csum_last(csum_last),
		.csum_done(csum_done),
		.csum_calc(csum_calc),
		.res_wr(res_wr),
		.res_entry(res_in)
	);

	transport_checksum u_csum (
		.m_axis_clk(m_axis_clk),
		.rst_n_m(rst_n_m),
		.data(s_axis.data),
		.valid(csum_valid),
		.last(csum_last),
		.done(csum_done),
		.calc(csum_calc)
	);

	// frame bytes.
	frame_fifo #(.payload_t(out_beat_t), .depth(`FRAME_FIFO_DEPTH)) u_frame_buf (
		.m_axis_clk(m_axis_clk),
		.rst_n_m(rst_n_m),
		.wr(buf_wr),
		.wr_data(buf_in),
		.rd(buf_rd),
		.rd_data(buf_out),
		.full(buf_full),
		.empty(buf_empty)
	);

	// one entry per stored frame.
	frame_fifo #(.payload_t(csum_result_t), .depth(`RESULT_FIFO_DEPTH)) u_result_buf (
		.m_axis_clk(m_axis_clk),
		.rst_n_m(rst_n_m),
		.wr(res_wr),
		.wr_data(res_in),
		.rd(res_rd),
		.rd_data(res_out),
		.full(res_full),
		.empty(res_empty)
	);

	egress_patcher u_patcher (
		.m_axis_clk(m_axis_clk),
		.rst_n_m(rst_n_m),
		.buf_beat(buf_out),
		.buf_empty(buf_empty),
		.buf_rd(buf_rd),
		.res_entry(res_out),
		.res_empty(res_empty),
		.res_rd(res_rd),
		.m_axis(m_axis),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready)
	);
endmodule

// ==== tests/frame_loop_assertions.sv ====
// bound to frame_loop; reaches the internal buffer write and full signals by name.
`timescale 1ns/10ps

module frame_loop_assertions (
	input logic m_axis_clk,
	input logic rst_n_m,
	input frame_loop_pkg::out_beat_t m_axis,
	input logic m_axis_tvalid,
	input logic m_axis_tready,
	input logic buf_wr,
	input logic buf_full
);
	// a stalled beat holds its data and valid.
	hold_under_stall: assert property (@(posedge m_axis_clk) disable iff (~rst_n_m)
		(m_axis_tvalid & ~m_axis_tready) |=> (m_axis_tvalid && $stable(m_axis)))
		else $error("output changed while stalled");

	// valid stays low once reset has been seen for a cycle.
	quiet_in_reset: assert property (@(posedge m_axis_clk)
		(~rst_n_m ##1 ~rst_n_m) |-> ~m_axis_tvalid)
		else $error("output valid during reset");

	no_write_when_full: assert property (@(posedge m_axis_clk) disable iff (~rst_n_m)
		buf_wr |-> ~buf_full)
		else $error("frame buffer written while full");
endmodule

bind frame_loop frame_loop_assertions u_assertions (
	.m_axis_clk(m_axis_clk),
	.rst_n_m(rst_n_m),
	.m_axis(m_axis),
	.m_axis_tvalid(m_axis_tvalid),
	.m_axis_tready(m_axis_tready),
	.buf_wr(buf_wr),
	.buf_full(buf_full)
);

// ==== tests/frame_loop_tb.sv ====
// rows before the stalled pair must leave the buffer drained; only the long row may overflow it.
`timescale 1ns/10ps
`include "frame_loop_cfg.svh"

module frame_loop_tb;
	import frame_loop_pkg::*;

	localparam int n_rows = 12;
	localparam int k_raw = 0;
	localparam int k_icmp = 1;
	localparam int k_udp = 2;
	localparam int k_tcp = 3;
	localparam int r_always = 0;
	localparam int r_random = 1;
	localparam int r_hold = 2;
	localparam int l4_ofs = `ETH_HDR_LEN + `IP_HDR_MIN;

	typedef struct {
		int kind;
		int len;
		logic mode;
		logic [1:0] user;
		int gap;
		int rdy;
	} row_t;

	logic m_axis_clk;
	logic rst_n_m;
	logic mode;
	in_beat_t s_axis;
	logic s_axis_tvalid;
	out_beat_t m_axis;
	logic m_axis_tvalid;
	logic m_axis_tready;

	row_t rows [n_rows];
	logic [7:0] frm [512];
	integer seed;
	logic first_in;
	int frames_out;
	out_beat_t exp_beats [$];
	int exp_len [$];
	logic exp_trunc [$];
	int exp_pos [$];
	logic [15:0] exp_field [$];
	out_beat_t got [$];

	frame_loop UUT (
		.m_axis_clk(m_axis_clk),
		.rst_n_m(rst_n_m),
		.mode(mode),
		.s_axis(s_axis),
		.s_axis_tvalid(s_axis_tvalid),
		.m_axis(m_axis),
		.m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready)
	);

	initial begin
		m_axis_clk = 1'b0;
		forever #2 m_axis_clk = ~m_axis_clk;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("=== FAIL ===");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_beat(input out_beat_t g, input out_beat_t e);
		if(g !== e) begin
			fail_run($sformatf("mismatch at %0t ns: beat %h, expected %h", $time, g, e));
		end
	endtask

	task automatic compare_result(input logic [15:0] g, input logic [15:0] e);
		if(g !== e) begin
			fail_run($sformatf("mismatch at %0t ns: checksum %h, expected %h", $time, g, e));
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame table
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic set_row(input int i, input int k, input int len, input logic m,
		input logic [1:0] u, input int gap, input int rdy);
		rows[i] = '{kind: k, len: len, mode: m, user: u, gap: gap, rdy: rdy};
	endtask

	task automatic load_table();
		set_row(0, k_raw, 60, 1'b1, 2'b10, 3, r_always);
		set_row(1, k_icmp, 64, 1'b1, 2'b10, 3, r_always);
		set_row(2, k_udp, 60, 1'b1, 2'b10, 2, r_always);
		set_row(3, k_tcp, 80, 1'b1, 2'b10, 2, r_random);
		set_row(4, k_udp, 71, 1'b0, 2'b10, 2, r_random);
		set_row(5, k_tcp, 66, 1'b1, 2'b00, 2, r_random);
		set_row(6, k_udp, 50, 1'b0, 2'b01, 0, r_random);
		// long gap drains the backlog.
		set_row(7, k_tcp, 90, 1'b1, 2'b11, 260, r_always);
		// stalled pair, the second overflows the buffer.
		set_row(8, k_udp, 60, 1'b1, 2'b10, 0, r_hold);
		set_row(9, k_udp, 300, 1'b1, 2'b10, 30, r_hold);
		set_row(10, k_tcp, 70, 1'b1, 2'b10, 5, r_always);
		set_row(11, k_udp, 61, 1'b1, 2'b10, 5, r_always);
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [7:0] proto_of(input int k);
		return (k == k_tcp) ? 8'd6 : (k == k_udp) ? 8'd17 : 8'd1;
	endfunction

	task automatic build_frame(input row_t r);
		int i;
		logic [15:0] tl;
		integer v;
		for(i = 0; i < r.len; i++) begin
			v = $random(seed);
			frm[i] = v[7:0];
		end
		frm[12] = 8'h08;
		frm[13] = (r.kind == k_raw) ? 8'h06 : 8'h00;
		if(r.kind != k_raw) begin
			tl = 16'(r.len - `ETH_HDR_LEN);
			frm[14] = 8'h45;
			frm[16] = tl[15:8];
			frm[17] = tl[7:0];
			frm[23] = proto_of(r.kind);
			tl = tl - 16'd20;
			if(r.kind == k_udp) begin
				frm[l4_ofs + 4] = tl[15:8];
				frm[l4_ofs + 5] = tl[7:0];
			end
		end
	endtask

	// pseudo-header addresses and L4 bytes as big-endian words by frame offset.
	function automatic logic [15:0] ref_csum(input row_t r, input int pos);
		int i;
		logic [31:0] s;
		s = 32'd0;
		for(i = 26; i < r.len; i++) begin
			if(i < 34 || (i != pos && i != pos + 1)) begin
				s = s + (i[0] ? {24'd0, frm[i]} : {16'd0, frm[i], 8'd0});
			end
		end
		s = s + {24'd0, proto_of(r.kind)} + 32'(r.len - l4_ofs);
		while(s[31:16] != 16'd0) begin
			s = {16'd0, s[15:0]} + {16'd0, s[31:16]};
		end
		return ~s[15:0];
	endfunction

	task automatic push_expected(input row_t r);
		int i;
		int pos;
		logic l4;
		logic trunc;
		logic patch;
		logic [15:0] cs;
		out_beat_t b;
		l4 = (r.kind == k_udp) || (r.kind == k_tcp);
		trunc = r.len > `FRAME_FIFO_DEPTH;
		pos = l4_ofs + ((r.kind == k_tcp) ? `TCP_CSUM_OFS : `UDP_CSUM_OFS);
		cs = ref_csum(r, pos);
		patch = l4 && r.mode && r.user[1] && !trunc && (cs != 16'h0000);
		for(i = 0; i < r.len; i++) begin
			b.data = frm[i];
			if(patch && i == pos) b.data = cs[15:8];
			if(patch && i == pos + 1) b.data = cs[7:0];
			b.user = (i == r.len - 1) && r.user[0];
			b.last = (i == r.len - 1);
			exp_beats.push_back(b);
		end
		exp_len.push_back(r.len);
		exp_trunc.push_back(trunc);
		exp_pos.push_back((l4 && !trunc) ? pos : -1);
		exp_field.push_back(patch ? cs : {frm[pos], frm[pos + 1]});
	endtask

	task automatic check_frame();
		int i;
		int n;
		int len;
		int pos;
		logic tr;
		logic [15:0] fld;
		out_beat_t e;
		if(exp_len.size() == 0) fail_run("a frame came out that was never sent");
		n = got.size();
		len = exp_len.pop_front();
		tr = exp_trunc.pop_front();
		pos = exp_pos.pop_front();
		fld = exp_field.pop_front();
		if(tr) begin
			if(n >= len) fail_run("the long frame was not cut short");
			for(i = 0; i < len; i++) begin
				e = exp_beats.pop_front();
				if(i < n - 1) compare_beat(got[i], e);
			end
			if(!(got[n - 1].user && got[n - 1].last)) begin
				fail_run("the cut frame has no error mark on its last beat");
			end
		end else begin
			if(n != len) begin
				fail_run($sformatf("mismatch at %0t ns: length %0d, expected %0d", $time, n, len));
			end
			for(i = 0; i < n; i++) begin
				e = exp_beats.pop_front();
				// the checksum field is checked as a word below.
				if(pos >= 0 && (i == pos || i == pos + 1)) e.data = got[i].data;
				compare_beat(got[i], e);
			end
			if(pos >= 0) compare_result({got[pos].data, got[pos + 1].data}, fld);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus, monitor and watchdog
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// one cycle of input, tready follows the row's pattern.
	task automatic step(input logic v, input in_beat_t b, input logic m, input int rdy,
		input logic busy);
		integer r;
		@(posedge m_axis_clk);
		#1;
		r = $random(seed);
		s_axis_tvalid = v;
		s_axis = b;
		mode = m;
		if(rdy == r_always) m_axis_tready = 1'b1;
		else if(rdy == r_random) m_axis_tready = r[0];
		else m_axis_tready = ~busy;
	endtask

	initial begin
		int ri;
		int i;
		in_beat_t b;
		seed = 32'h3e6b_5006;
		rst_n_m = 1'b0;
		mode = 1'b0;
		s_axis = '0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b0;
		first_in = 1'b0;
		load_table();
		repeat(5) @(posedge m_axis_clk);
		#1 rst_n_m = 1'b1;
		for(ri = 0; ri < n_rows; ri++) begin
			build_frame(rows[ri]);
			push_expected(rows[ri]);
			for(i = 0; i < rows[ri].len; i++) begin
				b.data = frm[i];
				b.user = rows[ri].user;
				b.last = (i == rows[ri].len - 1);
				step(1'b1, b, rows[ri].mode, rows[ri].rdy, 1'b1);
			end
			first_in = 1'b1;
			for(i = 0; i < rows[ri].gap; i++) begin
				step(1'b0, '0, rows[ri].mode, rows[ri].rdy, 1'b0);
			end
		end
		while(frames_out < n_rows) begin
			step(1'b0, '0, 1'b0, r_always, 1'b0);
		end
		if(exp_beats.size() == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			fail_run("expected bytes were left over after the last frame");
		end
	end

	// sampled mid-cycle, away from the drive and clock edges.
	initial begin
		frames_out = 0;
		forever begin
			@(negedge m_axis_clk);
			if(rst_n_m && m_axis_tvalid && !first_in) begin
				fail_run("output went valid before a whole frame had entered");
			end
			if(rst_n_m && m_axis_tvalid && m_axis_tready) begin
				got.push_back(m_axis);
				if(m_axis.last) begin
					check_frame();
					got.delete();
					frames_out++;
				end
			end
		end
	end

	initial begin
		int cycles;
		int r;
		#1;
		cycles = 0;
		for(r = 0; r < n_rows; r++) begin
			cycles += rows[r].len + rows[r].gap;
		end
		#(cycles * 16 + 4000);
		fail_run("timeout, not all frames came out");
	end
endmodule

// ==== frame_loop.f ====
+incdir+source
source/frame_loop_pkg.sv
source/transport_checksum.sv
source/frame_fifo.sv
source/ingress_guard.sv
source/egress_patcher.sv
source/frame_loop.sv
tests/frame_loop_assertions.sv
tests/frame_loop_tb.sv

// ==== Makefile ====
# Verilator flow for the frame loopback; sim passes only when the pass line is printed.

TB_TOP = frame_loop_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module frame_loop -f frame_loop.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f frame_loop.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
